// ==== all.f ====
design/csr_pkg.sv
design/csr_cause_enc.sv
design/csr_read_mux.sv
design/csr_regfile.sv
design/csr_unit.sv
tests/tb_clock_gen.sv
tests/tb_csr_unit.sv

// ==== design/csr_cause_enc.sv ====
`timescale 1ns/1ps

module csr_cause_enc
   (input  logic                                exc_v_i,
    input  logic [csr_pkg::ecode_dec_width-1:0] cause_dec_i,
    input  csr_pkg::irq_bits_s                  mie_i,
    input  csr_pkg::irq_bits_s                  mip_i,
    input  csr_pkg::mstatus_s                   mstatus_i,
    input  csr_pkg::priv_e                      priv_i,
    output csr_pkg::cause_s                     cause_o
   );

   logic [csr_pkg::xlen-1:0]            pend;
   logic [csr_pkg::ecode_dec_width-1:0] irq_vec;
   logic                                gie;

   // Index of the lowest set bit, lowest bit has priority
   function automatic logic [3:0] lowest_set
      (input logic [csr_pkg::ecode_dec_width-1:0] vec);
      logic [3:0] code;
      code = '0;
      for (int i = csr_pkg::ecode_dec_width - 1; i >= 0; i--)
      begin
         if (vec[i])
         begin
            code = 4'(i);
         end
      end
      return code;
   endfunction

   // Always enabled below M, gated by mstatus.mie in M
   assign gie = (priv_i == csr_pkg::priv_u) | mstatus_i.mie;

   assign pend    = mie_i & mip_i;
   assign irq_vec = pend[csr_pkg::ecode_dec_width-1:0] & {csr_pkg::ecode_dec_width{gie}};

   assign cause_o = '{take_irq: |irq_vec,
                      irq_code: lowest_set(irq_vec),
                      take_exc: exc_v_i & (|cause_dec_i),
                      exc_code: lowest_set(cause_dec_i)};

endmodule

// ==== design/csr_pkg.sv ====
package csr_pkg;

   // Datapath widths
   localparam int xlen            = 64;
   localparam int vaddr_width     = 39;
   localparam int instr_width     = 32;
   localparam int ecode_dec_width = 16;
   localparam int csr_addr_width  = 12;

   // Implemented CSR addresses
   localparam logic [csr_addr_width-1:0] addr_cycle         = 12'hC00;
   localparam logic [csr_addr_width-1:0] addr_instret       = 12'hC02;
   localparam logic [csr_addr_width-1:0] addr_mvendorid     = 12'hF11;
   localparam logic [csr_addr_width-1:0] addr_marchid       = 12'hF12;
   localparam logic [csr_addr_width-1:0] addr_mimpid        = 12'hF13;
   localparam logic [csr_addr_width-1:0] addr_mhartid       = 12'hF14;
   localparam logic [csr_addr_width-1:0] addr_mstatus       = 12'h300;
   localparam logic [csr_addr_width-1:0] addr_misa          = 12'h301;
   localparam logic [csr_addr_width-1:0] addr_mie           = 12'h304;
   localparam logic [csr_addr_width-1:0] addr_mtvec         = 12'h305;
   localparam logic [csr_addr_width-1:0] addr_mcounteren    = 12'h306;
   localparam logic [csr_addr_width-1:0] addr_mcountinhibit = 12'h320;
   localparam logic [csr_addr_width-1:0] addr_mscratch      = 12'h340;
   localparam logic [csr_addr_width-1:0] addr_mepc          = 12'h341;
   localparam logic [csr_addr_width-1:0] addr_mcause        = 12'h342;
   localparam logic [csr_addr_width-1:0] addr_mtval         = 12'h343;
   localparam logic [csr_addr_width-1:0] addr_mip           = 12'h344;
   localparam logic [csr_addr_width-1:0] addr_mcycle        = 12'hB00;
   localparam logic [csr_addr_width-1:0] addr_minstret      = 12'hB02;

   // Identity values
   localparam logic [xlen-1:0] marchid_value = 64'd13;
   localparam logic [xlen-1:0] mimpid_value  = 64'd1;
   // MXL of 2 means RV64; extension bits 8 (I) and 20 (U)
   localparam logic [xlen-1:0] misa_value    = {2'b10, 36'b0, 26'h0100100};

   typedef enum logic [1:0] {
      priv_u = 2'b00,
      priv_m = 2'b11
   } priv_e;

   typedef enum logic [3:0] {
      op_rw,
      op_rs,
      op_rc,
      op_rwi,
      op_rsi,
      op_rci,
      op_mret
   } csr_op_e;

   // Immediate forms take data[4:0]
   typedef struct packed {
      csr_op_e                   op;
      logic [csr_addr_width-1:0] addr;
      logic [xlen-1:0]           data;
   } csr_cmd_s;

   typedef struct packed {
      logic [63:13] rsvd_hi;
      logic [1:0]   mpp;
      logic [10:8]  rsvd_mid;
      logic         mpie;
      logic [6:4]   rsvd_lo;
      logic         mie;
      logic [2:0]   rsvd_wpri;
   } mstatus_s;

   // Shared by mip and mie
   typedef struct packed {
      logic [63:12] rsvd_hi;
      logic         mei;
      logic [10:8]  rsvd_mid;
      logic         mti;
      logic [6:4]   rsvd_lo;
      logic         msi;
      logic [2:0]   rsvd_u;
   } irq_bits_s;

   // Shared by mcounteren and mcountinhibit
   typedef struct packed {
      logic [63:3] rsvd_hi;
      logic        ir;
      logic        tm;
      logic        cy;
   } counter_ctl_s;

   typedef struct packed {
      logic        irq;
      logic [62:4] rsvd;
      logic [3:0]  ecode;
   } mcause_s;

   // Bit 2 of cause_dec is illegal instruction
   typedef struct packed {
      logic [vaddr_width-1:0]     pc;
      logic [vaddr_width-1:0]     vaddr;
      logic [instr_width-1:0]     instr;
      logic [ecode_dec_width-1:0] cause_dec;
   } exc_s;

   typedef struct packed {
      logic       take_irq;
      logic [3:0] irq_code;
      logic       take_exc;
      logic [3:0] exc_code;
   } cause_s;

   typedef struct packed {
      logic [xlen-1:0] epc;
      logic [xlen-1:0] tvec;
      logic            exception;
      logic            interrupt;
      logic            eret;
   } trap_pkt_s;

endpackage

// ==== design/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux
   (input  csr_pkg::csr_cmd_s        cmd_i,
    input  logic                     cmd_v_i,
    input  csr_pkg::priv_e           priv_i,
    input  csr_pkg::mstatus_s        mstatus_i,
    input  csr_pkg::irq_bits_s       mie_i,
    input  csr_pkg::irq_bits_s       mip_i,
    input  logic [csr_pkg::xlen-1:0] mtvec_i,
    input  logic [csr_pkg::xlen-1:0] mscratch_i,
    input  logic [csr_pkg::xlen-1:0] mepc_i,
    input  csr_pkg::mcause_s         mcause_i,
    input  logic [csr_pkg::xlen-1:0] mtval_i,
    input  csr_pkg::counter_ctl_s    mcounteren_i,
    input  csr_pkg::counter_ctl_s    mcountinhibit_i,
    input  logic [csr_pkg::xlen-1:0] mcycle_i,
    input  logic [csr_pkg::xlen-1:0] minstret_i,
    input  logic [csr_pkg::xlen-1:0] hartid_i,
    output logic [csr_pkg::xlen-1:0] rdata_o,
    output logic                     illegal_o
   );

   logic [csr_pkg::xlen-1:0] value;
   logic                     impl;
   logic                     is_mret;
   logic                     is_user;
   logic                     priv_low;
   logic                     cnt_block;
   logic                     bad;

   always_comb
   begin
      value = '0;
      impl  = 1'b1;
      case (cmd_i.addr)
         // User aliases read the machine counters
         csr_pkg::addr_cycle,
         csr_pkg::addr_mcycle:        value = mcycle_i;
         csr_pkg::addr_instret,
         csr_pkg::addr_minstret:      value = minstret_i;
         csr_pkg::addr_mvendorid:     value = '0;
         csr_pkg::addr_marchid:       value = csr_pkg::marchid_value;
         csr_pkg::addr_mimpid:        value = csr_pkg::mimpid_value;
         csr_pkg::addr_mhartid:       value = hartid_i;
         csr_pkg::addr_misa:          value = csr_pkg::misa_value;
         csr_pkg::addr_mstatus:       value = mstatus_i;
         csr_pkg::addr_mie:           value = mie_i;
         csr_pkg::addr_mip:           value = mip_i;
         csr_pkg::addr_mtvec:         value = mtvec_i;
         csr_pkg::addr_mscratch:      value = mscratch_i;
         csr_pkg::addr_mepc:          value = mepc_i;
         csr_pkg::addr_mcause:        value = mcause_i;
         csr_pkg::addr_mtval:         value = mtval_i;
         csr_pkg::addr_mcounteren:    value = mcounteren_i;
         csr_pkg::addr_mcountinhibit: value = mcountinhibit_i;
         default:                     impl  = 1'b0;
      endcase
   end

   assign is_mret  = (cmd_i.op == csr_pkg::op_mret);
   assign is_user  = (priv_i == csr_pkg::priv_u);
   assign priv_low = (priv_i < cmd_i.addr[9:8]);

   // Counter access from U mode needs the matching mcounteren bit
   assign cnt_block = is_user &
                      (((cmd_i.addr == csr_pkg::addr_cycle) & ~mcounteren_i.cy) |
                       ((cmd_i.addr == csr_pkg::addr_instret) & ~mcounteren_i.ir));

   assign bad = is_mret ? is_user : (~impl | priv_low | cnt_block);

   assign illegal_o = cmd_v_i & bad;
   assign rdata_o   = (cmd_v_i & ~bad & ~is_mret) ? value : '0;

endmodule

// ==== design/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile
   (input  logic                     clk_i,
    input  logic                     rst_i,
    input  csr_pkg::csr_cmd_s        cmd_i,
    input  logic                     cmd_v_i,
    input  logic [csr_pkg::xlen-1:0] rdata_i,
    input  logic                     illegal_i,
    input  csr_pkg::cause_s          cause_i,
    input  csr_pkg::exc_s            exc_i,
    input  logic [csr_pkg::xlen-1:0] irq_pc_i,
    input  logic                     timer_irq_i,
    input  logic                     software_irq_i,
    input  logic                     external_irq_i,
    input  logic                     instret_i,
    output csr_pkg::mstatus_s        mstatus_o,
    output csr_pkg::irq_bits_s       mie_o,
    output csr_pkg::irq_bits_s       mip_o,
    output logic [csr_pkg::xlen-1:0] mtvec_o,
    output logic [csr_pkg::xlen-1:0] mscratch_o,
    output logic [csr_pkg::xlen-1:0] mepc_o,
    output csr_pkg::mcause_s         mcause_o,
    output logic [csr_pkg::xlen-1:0] mtval_o,
    output csr_pkg::counter_ctl_s    mcounteren_o,
    output csr_pkg::counter_ctl_s    mcountinhibit_o,
    output logic [csr_pkg::xlen-1:0] mcycle_o,
    output logic [csr_pkg::xlen-1:0] minstret_o,
    output csr_pkg::priv_e           priv_o,
    output csr_pkg::trap_pkt_s       trap_pkt_o
   );

   csr_pkg::priv_e           priv_n;
   csr_pkg::mstatus_s        mstatus_n, wr_st;
   csr_pkg::irq_bits_s       mie_n, mip_n, wr_irq;
   csr_pkg::mcause_s         mcause_n;
   csr_pkg::counter_ctl_s    mcounteren_n, mcountinhibit_n, wr_cnt;
   logic [csr_pkg::xlen-1:0] mtvec_n, mscratch_n, mepc_n, mtval_n;
   logic [csr_pkg::xlen-1:0] mcycle_n, minstret_n;
   logic [csr_pkg::xlen-1:0] operand, wdata;
   logic                     take_trap, do_mret, wr_en;

   assign operand = (cmd_i.op inside {csr_pkg::op_rwi, csr_pkg::op_rsi, csr_pkg::op_rci})
                    ? csr_pkg::xlen'(cmd_i.data[4:0]) : cmd_i.data;

   always_comb
   begin
      case (cmd_i.op)
         csr_pkg::op_rw, csr_pkg::op_rwi: wdata = operand;
         csr_pkg::op_rs, csr_pkg::op_rsi: wdata = rdata_i | operand;
         csr_pkg::op_rc, csr_pkg::op_rci: wdata = rdata_i & ~operand;
         default:                         wdata = rdata_i;
      endcase
   end

   // Same word seen through each register layout
   assign wr_st  = wdata;
   assign wr_irq = wdata;
   assign wr_cnt = wdata;

   // Interrupt wins over exception and both win over the command
   assign take_trap = cause_i.take_irq | cause_i.take_exc;
   assign do_mret   = ~take_trap & cmd_v_i & ~illegal_i & (cmd_i.op == csr_pkg::op_mret);
   // Addresses with bits 11:10 set are read-only
   assign wr_en     = ~take_trap & cmd_v_i & ~illegal_i & (cmd_i.op != csr_pkg::op_mret) &
                      (cmd_i.addr[11:10] != 2'b11);

   always_comb
   begin
      priv_n          = priv_o;
      mstatus_n       = mstatus_o;
      mie_n           = mie_o;
      mtvec_n         = mtvec_o;
      mscratch_n      = mscratch_o;
      mepc_n          = mepc_o;
      mcause_n        = mcause_o;
      mtval_n         = mtval_o;
      mcounteren_n    = mcounteren_o;
      mcountinhibit_n = mcountinhibit_o;
      mcycle_n        = mcountinhibit_o.cy ? mcycle_o : mcycle_o + 1'b1;
      minstret_n      = mcountinhibit_o.ir ? minstret_o : minstret_o + csr_pkg::xlen'(instret_i);

      // mip follows the interrupt lines one cycle late
      mip_n     = '0;
      mip_n.msi = software_irq_i;
      mip_n.mti = timer_irq_i;
      mip_n.mei = external_irq_i;

      if (take_trap)
      begin
         priv_n         = csr_pkg::priv_m;
         mstatus_n.mpp  = priv_o;
         mstatus_n.mpie = mstatus_o.mie;
         mstatus_n.mie  = 1'b0;
         mcause_n       = '0;
         mcause_n.irq   = cause_i.take_irq;
         mcause_n.ecode = cause_i.take_irq ? cause_i.irq_code : cause_i.exc_code;
         if (cause_i.take_irq)
         begin
            mepc_n  = irq_pc_i;
            mtval_n = '0;
         end
         else
         begin
            mepc_n  = csr_pkg::xlen'($signed(exc_i.pc));
            mtval_n = exc_i.cause_dec[2] ? csr_pkg::xlen'(exc_i.instr)
                                         : csr_pkg::xlen'($signed(exc_i.vaddr));
         end
      end
      else if (do_mret)
      begin
         priv_n         = csr_pkg::priv_e'(mstatus_o.mpp);
         mstatus_n.mpp  = csr_pkg::priv_u;
         mstatus_n.mpie = 1'b1;
         mstatus_n.mie  = mstatus_o.mpie;
      end
      else if (wr_en)
      begin
         case (cmd_i.addr)
            csr_pkg::addr_mstatus:
            begin
               mstatus_n      = '0;
               mstatus_n.mie  = wr_st.mie;
               mstatus_n.mpie = wr_st.mpie;
               // Only U and M exist, so the high bit picks the mode
               mstatus_n.mpp  = wr_st.mpp[1] ? csr_pkg::priv_m : csr_pkg::priv_u;
            end
            csr_pkg::addr_mie:
            begin
               mie_n     = '0;
               mie_n.msi = wr_irq.msi;
               mie_n.mti = wr_irq.mti;
               mie_n.mei = wr_irq.mei;
            end
            csr_pkg::addr_mcounteren:
            begin
               mcounteren_n    = '0;
               mcounteren_n.cy = wr_cnt.cy;
               mcounteren_n.ir = wr_cnt.ir;
            end
            csr_pkg::addr_mcountinhibit:
            begin
               mcountinhibit_n    = '0;
               mcountinhibit_n.cy = wr_cnt.cy;
               mcountinhibit_n.ir = wr_cnt.ir;
            end
            csr_pkg::addr_mtvec:    mtvec_n    = wdata;
            csr_pkg::addr_mscratch: mscratch_n = wdata;
            csr_pkg::addr_mepc:     mepc_n     = wdata;
            csr_pkg::addr_mcause:   mcause_n   = wdata;
            csr_pkg::addr_mtval:    mtval_n    = wdata;
            // A counter write replaces this cycle's increment
            csr_pkg::addr_mcycle:   mcycle_n   = wdata;
            csr_pkg::addr_minstret: minstret_n = wdata;
            // Writes to mip are ignored
            default:                ;
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         priv_o          <= csr_pkg::priv_m;
         mstatus_o       <= '0;
         mie_o           <= '0;
         mip_o           <= '0;
         mtvec_o         <= '0;
         mscratch_o      <= '0;
         mepc_o          <= '0;
         mcause_o        <= '0;
         mtval_o         <= '0;
         mcounteren_o    <= '0;
         mcountinhibit_o <= '0;
         mcycle_o        <= '0;
         minstret_o      <= '0;
      end
      else
      begin
         priv_o          <= priv_n;
         mstatus_o       <= mstatus_n;
         mie_o           <= mie_n;
         mip_o           <= mip_n;
         mtvec_o         <= mtvec_n;
         mscratch_o      <= mscratch_n;
         mepc_o          <= mepc_n;
         mcause_o        <= mcause_n;
         mtval_o         <= mtval_n;
         mcounteren_o    <= mcounteren_n;
         mcountinhibit_o <= mcountinhibit_n;
         mcycle_o        <= mcycle_n;
         minstret_o      <= minstret_n;
      end
   end

   assign trap_pkt_o = '{epc:       mepc_o,
                         tvec:      mtvec_o,
                         exception: cause_i.take_exc & ~cause_i.take_irq,
                         interrupt: cause_i.take_irq,
                         eret:      do_mret};

endmodule

// ==== design/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit
   (input  logic                     clk_i,
    input  logic                     rst_i,
    input  csr_pkg::csr_cmd_s        cmd_i,
    input  logic                     cmd_v_i,
    input  csr_pkg::exc_s            exc_i,
    input  logic                     exc_v_i,
    input  logic                     timer_irq_i,
    input  logic                     software_irq_i,
    input  logic                     external_irq_i,
    input  logic [csr_pkg::xlen-1:0] irq_pc_i,
    input  logic                     instret_i,
    input  logic [csr_pkg::xlen-1:0] hartid_i,
    output logic [csr_pkg::xlen-1:0] data_o,
    output logic                     v_o,
    output logic                     illegal_o,
    output csr_pkg::trap_pkt_s       trap_pkt_o,
    output csr_pkg::priv_e           priv_o
   );

   csr_pkg::mstatus_s        mstatus;
   csr_pkg::irq_bits_s       mie, mip;
   csr_pkg::mcause_s         mcause;
   csr_pkg::counter_ctl_s    mcounteren, mcountinhibit;
   csr_pkg::cause_s          cause;
   logic [csr_pkg::xlen-1:0] mtvec, mscratch, mepc, mtval, mcycle, minstret;

   // Commands complete in the cycle they arrive
   assign v_o = cmd_v_i;

   csr_cause_enc u_cause_enc
      (.exc_v_i     (exc_v_i),
       .cause_dec_i (exc_i.cause_dec),
       .mie_i       (mie),
       .mip_i       (mip),
       .mstatus_i   (mstatus),
       .priv_i      (priv_o),
       .cause_o     (cause));

   csr_read_mux u_read_mux
      (.cmd_i           (cmd_i),
       .cmd_v_i         (cmd_v_i),
       .priv_i          (priv_o),
       .mstatus_i       (mstatus),
       .mie_i           (mie),
       .mip_i           (mip),
       .mtvec_i         (mtvec),
       .mscratch_i      (mscratch),
       .mepc_i          (mepc),
       .mcause_i        (mcause),
       .mtval_i         (mtval),
       .mcounteren_i    (mcounteren),
       .mcountinhibit_i (mcountinhibit),
       .mcycle_i        (mcycle),
       .minstret_i      (minstret),
       .hartid_i        (hartid_i),
       .rdata_o         (data_o),
       .illegal_o       (illegal_o));

   csr_regfile u_regfile
      (.clk_i           (clk_i),
       .rst_i           (rst_i),
       .cmd_i           (cmd_i),
       .cmd_v_i         (cmd_v_i),
       .rdata_i         (data_o),
       .illegal_i       (illegal_o),
       .cause_i         (cause),
       .exc_i           (exc_i),
       .irq_pc_i        (irq_pc_i),
       .timer_irq_i     (timer_irq_i),
       .software_irq_i  (software_irq_i),
       .external_irq_i  (external_irq_i),
       .instret_i       (instret_i),
       .mstatus_o       (mstatus),
       .mie_o           (mie),
       .mip_o           (mip),
       .mtvec_o         (mtvec),
       .mscratch_o      (mscratch),
       .mepc_o          (mepc),
       .mcause_o        (mcause),
       .mtval_o         (mtval),
       .mcounteren_o    (mcounteren),
       .mcountinhibit_o (mcountinhibit),
       .mcycle_o        (mcycle),
       .minstret_o      (minstret),
       .priv_o          (priv_o),
       .trap_pkt_o      (trap_pkt_o));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_csr_unit -f all.f -o sim_csr_unit

./obj_dir/sim_csr_unit 2>&1 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failure"

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
   (output logic clk_o
   );

   localparam int half_period = 20;

   // 40 ns period, first rising edge at 20 ns
   initial
   begin
      clk_o = 1'b0;
      forever
      begin
         #half_period;
         clk_o = ~clk_o;
      end
   end

endmodule

// ==== tests/tb_csr_unit.sv ====
`timescale 1ns/1ps

module tb_csr_unit;

   localparam int num_cycles    = 4000;
   localparam int reset_timeout = 10;

   logic                     clk;
   logic                     rst;
   csr_pkg::csr_cmd_s        cmd;
   logic                     cmd_v;
   csr_pkg::exc_s            exc;
   logic                     exc_v;
   logic                     timer_irq;
   logic                     software_irq;
   logic                     external_irq;
   logic [csr_pkg::xlen-1:0] irq_pc;
   logic                     instret;
   logic [csr_pkg::xlen-1:0] hartid;
   logic [csr_pkg::xlen-1:0] data;
   logic                     v;
   logic                     illegal;
   csr_pkg::trap_pkt_s       trap_pkt;
   csr_pkg::priv_e           priv;

   // Reference model state
   csr_pkg::priv_e m_priv;
   logic [63:0]    m_mstatus, m_mie, m_mip, m_mtvec, m_mscratch, m_mepc;
   logic [63:0]    m_mcause, m_mtval, m_cen, m_cinh, m_mcycle, m_minstret;

   logic [31:0] lfsr;
   logic [11:0] impl_addr [0:18];
   int          n_irq, n_exc, n_eret, n_user, n_illegal;

   tb_clock_gen u_clock_gen
      (.clk_o (clk));

   csr_unit dut
      (.clk_i          (clk),
       .rst_i          (rst),
       .cmd_i          (cmd),
       .cmd_v_i        (cmd_v),
       .exc_i          (exc),
       .exc_v_i        (exc_v),
       .timer_irq_i    (timer_irq),
       .software_irq_i (software_irq),
       .external_irq_i (external_irq),
       .irq_pc_i       (irq_pc),
       .instret_i      (instret),
       .hartid_i       (hartid),
       .data_o         (data),
       .v_o            (v),
       .illegal_o      (illegal),
       .trap_pkt_o     (trap_pkt),
       .priv_o         (priv));

   // Galois LFSR, one step per bit handed out
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r    = {r[62:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [3:0] lowest_bit(input logic [15:0] vec);
      logic [3:0] idx;
      logic       found;
      idx   = '0;
      found = 1'b0;
      for (int i = 0; i < 16; i++)
      begin
         if (vec[i] && !found)
         begin
            idx   = 4'(i);
            found = 1'b1;
         end
      end
      return idx;
   endfunction

   // Value a CSR read should return, flags unimplemented addresses
   function automatic logic [63:0] model_read(input logic [11:0] addr, output logic impl);
      logic [63:0] val;
      val  = '0;
      impl = 1'b1;
      case (addr)
         csr_pkg::addr_cycle, csr_pkg::addr_mcycle:     val = m_mcycle;
         csr_pkg::addr_instret, csr_pkg::addr_minstret: val = m_minstret;
         csr_pkg::addr_mvendorid:     val = '0;
         csr_pkg::addr_marchid:       val = 64'd13;
         csr_pkg::addr_mimpid:        val = 64'd1;
         csr_pkg::addr_mhartid:       val = hartid;
         // RV64 with I and U
         csr_pkg::addr_misa:          val = 64'h8000_0000_0010_0100;
         csr_pkg::addr_mstatus:       val = m_mstatus;
         csr_pkg::addr_mie:           val = m_mie;
         csr_pkg::addr_mip:           val = m_mip;
         csr_pkg::addr_mtvec:         val = m_mtvec;
         csr_pkg::addr_mscratch:      val = m_mscratch;
         csr_pkg::addr_mepc:          val = m_mepc;
         csr_pkg::addr_mcause:        val = m_mcause;
         csr_pkg::addr_mtval:         val = m_mtval;
         csr_pkg::addr_mcounteren:    val = m_cen;
         csr_pkg::addr_mcountinhibit: val = m_cinh;
         default:                     impl = 1'b0;
      endcase
      return val;
   endfunction

   task automatic abort_run();
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_word(input string name, input logic [csr_pkg::xlen-1:0] got,
                             input logic [csr_pkg::xlen-1:0] exp);
      if (got !== exp)
      begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_priv(input string name, input csr_pkg::priv_e got,
                             input csr_pkg::priv_e exp);
      if (got !== exp)
      begin
         $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_trap(input string name, input csr_pkg::trap_pkt_s got,
                             input csr_pkg::trap_pkt_s exp);
      if (got !== exp)
      begin
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic reset_model();
      m_priv     = csr_pkg::priv_m;
      m_mstatus  = '0;
      m_mie      = '0;
      m_mip      = '0;
      m_mtvec    = '0;
      m_mscratch = '0;
      m_mepc     = '0;
      m_mcause   = '0;
      m_mtval    = '0;
      m_cen      = '0;
      m_cinh     = '0;
      m_mcycle   = '0;
      m_minstret = '0;
   endtask

   task automatic drive_idle();
      cmd          = '0;
      cmd_v        = 1'b0;
      exc          = '0;
      exc_v        = 1'b0;
      timer_irq    = 1'b0;
      software_irq = 1'b0;
      external_irq = 1'b0;
      irq_pc       = '0;
      instret      = 1'b0;
   endtask

   task automatic drive_random();
      logic [4:0] sel;
      logic [2:0] opv;
      sel      = 5'(rand_bits(5));
      opv      = 3'(rand_bits(3));
      cmd_v    = (rand_bits(3) != '0);
      // mret gets one slot in eight
      cmd.op   = (opv == 3'd7) ? csr_pkg::op_rw : csr_pkg::csr_op_e'({1'b0, opv});
      cmd.addr = (sel < 5'd19) ? impl_addr[sel] : 12'(rand_bits(12));
      cmd.data = rand_bits(64);
      exc_v          = (rand_bits(4) == '0);
      exc.pc         = 39'(rand_bits(39));
      exc.vaddr      = 39'(rand_bits(39));
      exc.instr      = 32'(rand_bits(32));
      exc.cause_dec  = 16'(rand_bits(16));
      timer_irq      = (rand_bits(3) == '0);
      software_irq   = (rand_bits(3) == '0);
      external_irq   = (rand_bits(3) == '0);
      irq_pc         = rand_bits(64);
      instret        = 1'(rand_bits(1));
   endtask

   // Compare this cycle's outputs, then advance the model across the next edge
   task automatic check_and_step();
      logic [63:0]        rd, opnd, wd, exp_data, nxt_cycle, nxt_instret;
      logic [15:0]        pend;
      logic               impl, is_mret, bad, gie, take_irq, take_exc, do_mret, old_mpie;
      csr_pkg::trap_pkt_s exp_trap;

      rd      = model_read(cmd.addr, impl);
      is_mret = (cmd.op == csr_pkg::op_mret);
      if (is_mret)
      begin
         bad = (m_priv == csr_pkg::priv_u);
      end
      else
      begin
         bad = !impl || (m_priv < cmd.addr[9:8]) ||
               ((m_priv == csr_pkg::priv_u) &&
                (((cmd.addr == csr_pkg::addr_cycle) && !m_cen[0]) ||
                 ((cmd.addr == csr_pkg::addr_instret) && !m_cen[2])));
      end
      exp_data = (cmd_v && !bad && !is_mret) ? rd : '0;

      gie      = (m_priv == csr_pkg::priv_u) || m_mstatus[3];
      pend     = m_mie[15:0] & m_mip[15:0] & {16{gie}};
      take_irq = |pend;
      take_exc = exc_v && (|exc.cause_dec);
      do_mret  = !take_irq && !take_exc && cmd_v && !bad && is_mret;

      exp_trap.epc       = m_mepc;
      exp_trap.tvec      = m_mtvec;
      exp_trap.exception = take_exc && !take_irq;
      exp_trap.interrupt = take_irq;
      exp_trap.eret      = do_mret;

      check_bit("v_o", v, cmd_v);
      check_bit("illegal_o", illegal, cmd_v && bad);
      check_word("data_o", data, exp_data);
      check_priv("priv_o", priv, m_priv);
      check_trap("trap_pkt_o", trap_pkt, exp_trap);

      if (take_irq)
         n_irq++;
      else if (take_exc)
         n_exc++;
      if (do_mret)
         n_eret++;
      if (m_priv == csr_pkg::priv_u)
         n_user++;
      if (cmd_v && bad)
         n_illegal++;

      nxt_cycle   = m_cinh[0] ? m_mcycle : m_mcycle + 64'd1;
      nxt_instret = m_cinh[2] ? m_minstret : m_minstret + {63'd0, instret};

      if (take_irq || take_exc)
      begin
         m_mstatus[12:11] = m_priv;
         m_mstatus[7]     = m_mstatus[3];
         m_mstatus[3]     = 1'b0;
         m_priv           = csr_pkg::priv_m;
         if (take_irq)
         begin
            m_mepc   = irq_pc;
            m_mcause = {1'b1, 59'd0, lowest_bit(pend)};
            m_mtval  = '0;
         end
         else
         begin
            m_mepc   = {{25{exc.pc[38]}}, exc.pc};
            m_mcause = {1'b0, 59'd0, lowest_bit(exc.cause_dec)};
            m_mtval  = exc.cause_dec[2] ? {32'd0, exc.instr} : {{25{exc.vaddr[38]}}, exc.vaddr};
         end
      end
      else if (do_mret)
      begin
         old_mpie         = m_mstatus[7];
         m_priv           = csr_pkg::priv_e'(m_mstatus[12:11]);
         m_mstatus[12:11] = 2'b00;
         m_mstatus[7]     = 1'b1;
         m_mstatus[3]     = old_mpie;
      end
      else if (cmd_v && !bad && !is_mret && (cmd.addr[11:10] != 2'b11))
      begin
         if ((cmd.op == csr_pkg::op_rwi) || (cmd.op == csr_pkg::op_rsi) ||
             (cmd.op == csr_pkg::op_rci))
            opnd = {59'd0, cmd.data[4:0]};
         else
            opnd = cmd.data;
         case (cmd.op)
            csr_pkg::op_rw, csr_pkg::op_rwi: wd = opnd;
            csr_pkg::op_rs, csr_pkg::op_rsi: wd = rd | opnd;
            default:                         wd = rd & ~opnd;
         endcase
         case (cmd.addr)
            csr_pkg::addr_mstatus:
               m_mstatus = {51'd0, (wd[12] ? 2'b11 : 2'b00), 3'd0, wd[7], 3'd0, wd[3], 3'd0};
            csr_pkg::addr_mie:           m_mie      = wd & 64'h888;
            csr_pkg::addr_mcounteren:    m_cen      = wd & 64'h5;
            csr_pkg::addr_mcountinhibit: m_cinh     = wd & 64'h5;
            csr_pkg::addr_mtvec:         m_mtvec    = wd;
            csr_pkg::addr_mscratch:      m_mscratch = wd;
            csr_pkg::addr_mepc:          m_mepc     = wd;
            csr_pkg::addr_mcause:        m_mcause   = wd;
            csr_pkg::addr_mtval:         m_mtval    = wd;
            csr_pkg::addr_mcycle:        nxt_cycle   = wd;
            csr_pkg::addr_minstret:      nxt_instret = wd;
            default:                     ;
         endcase
      end
      m_mcycle   = nxt_cycle;
      m_minstret = nxt_instret;
      m_mip      = {52'd0, external_irq, 3'd0, timer_irq, 3'd0, software_irq, 3'd0};
   endtask

   initial
   begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
   end

   initial
   begin
      logic [11:0] id_addr [0:4];
      int          waited;
      lfsr      = 32'd30521;
      impl_addr = '{csr_pkg::addr_cycle, csr_pkg::addr_instret, csr_pkg::addr_mvendorid,
                    csr_pkg::addr_marchid, csr_pkg::addr_mimpid, csr_pkg::addr_mhartid,
                    csr_pkg::addr_mstatus, csr_pkg::addr_misa, csr_pkg::addr_mie,
                    csr_pkg::addr_mtvec, csr_pkg::addr_mcounteren,
                    csr_pkg::addr_mcountinhibit, csr_pkg::addr_mscratch, csr_pkg::addr_mepc,
                    csr_pkg::addr_mcause, csr_pkg::addr_mtval, csr_pkg::addr_mip,
                    csr_pkg::addr_mcycle, csr_pkg::addr_minstret};
      id_addr   = '{csr_pkg::addr_mvendorid, csr_pkg::addr_marchid, csr_pkg::addr_mimpid,
                    csr_pkg::addr_mhartid, csr_pkg::addr_misa};
      drive_idle();
      hartid    = rand_bits(64);
      n_irq     = 0;
      n_exc     = 0;
      n_eret    = 0;
      n_user    = 0;
      n_illegal = 0;

      waited = 0;
      @(negedge clk);
      while (rst)
      begin
         waited++;
         if (waited > reset_timeout)
         begin
            $display("reset was still asserted after %0d cycles", reset_timeout);
            abort_run();
         end
         @(negedge clk);
      end
      reset_model();
      check_and_step();

      // Identity registers, read with a set of zero
      for (int i = 0; i < 5; i++)
      begin
         @(posedge clk);
         #1;
         drive_idle();
         cmd.op   = csr_pkg::op_rs;
         cmd.addr = id_addr[i];
         cmd_v    = 1'b1;
         @(negedge clk);
         check_and_step();
      end

      for (int i = 0; i < num_cycles; i++)
      begin
         @(posedge clk);
         #1;
         drive_random();
         @(negedge clk);
         check_and_step();
      end

      if ((n_irq == 0) || (n_exc == 0) || (n_eret == 0) || (n_user == 0) || (n_illegal == 0))
      begin
         $display("random run missed a case: irq %0d exc %0d mret %0d user %0d illegal %0d",
                  n_irq, n_exc, n_eret, n_user, n_illegal);
         abort_run();
      end
      else
      begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule
